// File: hdl/seg_game_pkg.sv
`default_nettype none

package seg_game_pkg;

    // Tick divisors in clk cycles, scaled down for simulation
    localparam int SAMPLE_DIV = 4;
    localparam int HALF_DIV = 128;
    localparam int SECOND_DIV = 256;

    // Consecutive high samples for a debounced press
    localparam int DEBOUNCE_LEN = 4;

    // Second ticks spent waiting in INITIAL
    localparam int INITIAL_SECONDS = 3;

    localparam int NUM_SEGS = 7;
    localparam int RING_SEGS = 6;

    // Segment index, 0 to 6 for a to g
    typedef logic [2:0] seg_idx_t;

    // One bit per segment, bit i is segment i
    typedef logic [NUM_SEGS-1:0] seg_vec_t;

    // Count of second ticks seen in INITIAL
    typedef logic [1:0] sec_count_t;

    // Free running divider count
    typedef logic [7:0] tick_count_t;

    // Segments the cursor jumps to
    localparam seg_idx_t SEG_A = 3'd0;
    localparam seg_idx_t SEG_B = 3'd1;
    localparam seg_idx_t SEG_F = 3'd5;
    localparam seg_idx_t SEG_G = 3'd6;

    typedef enum logic [1:0] {
        INITIAL = 2'd0,
        MOVING  = 2'd1,
        FALLING = 2'd2
    } game_state_t;

endpackage

`default_nettype wire

// File: hdl/tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tick_gen (
    input  logic clk,
    input  logic rst,
    output logic tick_sample,
    output logic tick_half,
    output logic tick_second
);

    seg_game_pkg::tick_count_t count;

    // Single free counter, one full wrap per second tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (int'(count) == seg_game_pkg::SECOND_DIV - 1) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Each enable fires on the last cycle of its period
    assign tick_sample =
        (int'(count) % seg_game_pkg::SAMPLE_DIV) == seg_game_pkg::SAMPLE_DIV - 1;
    assign tick_half =
        (int'(count) % seg_game_pkg::HALF_DIV) == seg_game_pkg::HALF_DIV - 1;
    assign tick_second =
        int'(count) == seg_game_pkg::SECOND_DIV - 1;

    // Flasher and FSM rely on the second tick landing on a half tick
    assert property (@(posedge clk) disable iff (rst) tick_second |-> tick_half)
        else $error("tick_second without tick_half");

endmodule

`default_nettype wire

// File: hdl/button_conditioner.sv
`timescale 1ns/1ps
`default_nettype none

module button_conditioner (
    input  logic clk,
    input  logic rst,
    input  logic tick_sample,
    input  logic button,
    output logic press
);

    localparam int LEN = seg_game_pkg::DEBOUNCE_LEN;

    logic [LEN-1:0] history;
    logic [LEN-1:0] next_history;
    logic           debounced;
    logic           all_high;

    // History as it will look after the current sample
    assign next_history = {history[LEN-2:0], button};
    assign all_high = &next_history;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            history   <= '0;
            debounced <= 1'b0;
        end else if (tick_sample) begin
            history   <= next_history;
            debounced <= all_high;
        end
    end

    // Rising edge of the debounced level, only on a sample tick
    assign press = tick_sample && all_high && !debounced;

    // Sample ticks are several cycles apart, so a press is always one cycle
    assert property (@(posedge clk) disable iff (rst) press |=> !press)
        else $error("press held for two cycles");

endmodule

`default_nettype wire

// File: hdl/cursor_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cursor_fsm (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      tick_half,
    input  logic                      tick_second,
    input  logic                      press_right,
    input  logic                      press_left,
    input  logic                      press_up,
    input  logic                      press_down,
    output seg_game_pkg::seg_idx_t    head,
    output seg_game_pkg::seg_vec_t    record,
    output seg_game_pkg::game_state_t state_out
);

    seg_game_pkg::game_state_t state;
    seg_game_pkg::game_state_t next_state;
    seg_game_pkg::sec_count_t  sec_count;
    seg_game_pkg::seg_idx_t    next_head;
    seg_game_pkg::seg_vec_t    stamped;

    assign state_out = state;

    // Record with the cursor segment added
    assign stamped = record | (seg_game_pkg::seg_vec_t'(1) << head);

    always_comb begin
        next_state = state;
        case (state)
            seg_game_pkg::INITIAL: begin
                if (tick_second &&
                    int'(sec_count) == seg_game_pkg::INITIAL_SECONDS - 1) begin
                    next_state = seg_game_pkg::MOVING;
                end
            end
            seg_game_pkg::MOVING: begin
                if (press_down) begin
                    next_state = seg_game_pkg::FALLING;
                end
            end
            seg_game_pkg::FALLING: begin
                if (tick_half) begin
                    next_state = seg_game_pkg::INITIAL;
                end
            end
            default: next_state = seg_game_pkg::INITIAL;
        endcase
    end

    // Cursor movement, up wins over right and right over left
    always_comb begin
        next_head = head;
        if (press_up) begin
            next_head = (head == seg_game_pkg::SEG_G) ? seg_game_pkg::SEG_A
                                                      : seg_game_pkg::SEG_G;
        end else if (press_right) begin
            if (head == seg_game_pkg::SEG_G) begin
                next_head = seg_game_pkg::SEG_B;
            end else if (int'(head) == seg_game_pkg::RING_SEGS - 1) begin
                next_head = seg_game_pkg::SEG_A;
            end else begin
                next_head = head + 1'b1;
            end
        end else if (press_left) begin
            if (head == seg_game_pkg::SEG_G) begin
                next_head = seg_game_pkg::SEG_F;
            end else if (head == seg_game_pkg::SEG_A) begin
                next_head = seg_game_pkg::seg_idx_t'(seg_game_pkg::RING_SEGS - 1);
            end else begin
                next_head = head - 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= seg_game_pkg::INITIAL;
        end else begin
            state <= next_state;
        end
    end

    // Counts seconds only while waiting, cleared everywhere else
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sec_count <= '0;
        end else if (state != seg_game_pkg::INITIAL) begin
            sec_count <= '0;
        end else if (tick_second) begin
            sec_count <= sec_count + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head   <= seg_game_pkg::SEG_A;
            record <= '0;
        end else if (state == seg_game_pkg::MOVING) begin
            if (press_down) begin
                // A full record starts over empty
                record <= (&stamped) ? '0 : stamped;
            end else begin
                head <= next_head;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) head <= seg_game_pkg::SEG_G)
        else $error("cursor index out of range");

endmodule

`default_nettype wire

// File: hdl/segment_flasher.sv
`timescale 1ns/1ps
`default_nettype none

module segment_flasher (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tick_half,
    input  seg_game_pkg::seg_idx_t head,
    input  seg_game_pkg::seg_vec_t record,
    output seg_game_pkg::seg_vec_t seg_n
);

    logic flash_phase;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flash_phase <= 1'b0;
        end else if (tick_half) begin
            flash_phase <= ~flash_phase;
        end
    end

    // Active low, recorded segments lit
    always_comb begin
        seg_n = ~record;
        // Cursor blinks against whatever the record shows
        if (flash_phase) begin
            seg_n[head] = ~seg_n[head];
        end
    end

endmodule

`default_nettype wire

// File: hdl/seg_game_top.sv
`timescale 1ns/1ps
`default_nettype none

module seg_game_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      right,
    input  logic                      left,
    input  logic                      up,
    input  logic                      down,
    output seg_game_pkg::seg_vec_t    seg_n,
    output seg_game_pkg::seg_idx_t    pos,
    output seg_game_pkg::game_state_t state_out
);

    logic                   tick_sample;
    logic                   tick_half;
    logic                   tick_second;
    logic                   press_right;
    logic                   press_left;
    logic                   press_up;
    logic                   press_down;
    seg_game_pkg::seg_vec_t record;

    tick_gen u_tick_gen (
        .clk         (clk),
        .rst         (rst),
        .tick_sample (tick_sample),
        .tick_half   (tick_half),
        .tick_second (tick_second)
    );

    button_conditioner cond_right (
        .clk         (clk),
        .rst         (rst),
        .tick_sample (tick_sample),
        .button      (right),
        .press       (press_right)
    );

    button_conditioner cond_left (
        .clk         (clk),
        .rst         (rst),
        .tick_sample (tick_sample),
        .button      (left),
        .press       (press_left)
    );

    button_conditioner cond_up (
        .clk         (clk),
        .rst         (rst),
        .tick_sample (tick_sample),
        .button      (up),
        .press       (press_up)
    );

    button_conditioner cond_down (
        .clk         (clk),
        .rst         (rst),
        .tick_sample (tick_sample),
        .button      (down),
        .press       (press_down)
    );

    cursor_fsm u_cursor_fsm (
        .clk         (clk),
        .rst         (rst),
        .tick_half   (tick_half),
        .tick_second (tick_second),
        .press_right (press_right),
        .press_left  (press_left),
        .press_up    (press_up),
        .press_down  (press_down),
        .head        (pos),
        .record      (record),
        .state_out   (state_out)
    );

    segment_flasher u_segment_flasher (
        .clk         (clk),
        .rst         (rst),
        .tick_half   (tick_half),
        .head        (pos),
        .record      (record),
        .seg_n       (seg_n)
    );

endmodule

`default_nettype wire

// File: dv/seg_game_checker.sv
`timescale 1ns/1ps
`default_nettype none

module seg_game_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  seg_game_pkg::seg_vec_t    seg_n,
    input  seg_game_pkg::seg_idx_t    pos,
    input  seg_game_pkg::game_state_t state_out,
    input  logic                      check_req,
    input  int                        check_step,
    input  seg_game_pkg::seg_idx_t    exp_pos,
    input  seg_game_pkg::seg_vec_t    exp_record,
    input  seg_game_pkg::game_state_t exp_state,
    output int                        test_count,
    output int                        error_count
);

    // Cycles since reset release, 1 at the first falling edge after it
    int                        cyc;
    int                        entry_cyc;
    seg_game_pkg::game_state_t prev_state;

    // First cycle that follows a period boundary strictly after from
    function automatic int next_boundary(input int from, input int period);
        return ((from - 1) / period + 1) * period + 1;
    endfunction

    // Flash phase flips every half period counted from reset release
    function automatic seg_game_pkg::seg_vec_t expected_seg_n(input int at_cyc);
        seg_game_pkg::seg_vec_t seg;
        seg = ~exp_record;
        if (((at_cyc - 1) / seg_game_pkg::HALF_DIV) % 2 == 1) begin
            seg[exp_pos] = ~seg[exp_pos];
        end
        return seg;
    endfunction

    task automatic check_entry_time(input string what, input int want);
        test_count++;
        if (cyc != want) begin
            $display("MISMATCH at %0t: %s at cycle %0d, expected cycle %0d",
                     $time, what, cyc, want);
            error_count++;
        end else begin
            $display("%s at cycle %0d ok", what, cyc);
        end
    endtask

    task automatic check_transition();
        logic legal;
        legal = (prev_state == seg_game_pkg::INITIAL && state_out == seg_game_pkg::MOVING) ||
                (prev_state == seg_game_pkg::MOVING && state_out == seg_game_pkg::FALLING) ||
                (prev_state == seg_game_pkg::FALLING && state_out == seg_game_pkg::INITIAL);
        if (!legal) begin
            $display("Illegal state change from %s to %s at %0t",
                     prev_state.name(), state_out.name(), $time);
            test_count++;
            error_count++;
        end else if (state_out == seg_game_pkg::MOVING) begin
            // Third second tick counted after INITIAL was entered
            check_entry_time("INITIAL to MOVING",
                             next_boundary(entry_cyc, seg_game_pkg::SECOND_DIV) +
                             (seg_game_pkg::INITIAL_SECONDS - 1) * seg_game_pkg::SECOND_DIV);
        end else if (state_out == seg_game_pkg::INITIAL) begin
            check_entry_time("FALLING to INITIAL",
                             next_boundary(entry_cyc, seg_game_pkg::HALF_DIV));
        end
        prev_state = state_out;
        entry_cyc  = cyc;
    endtask

    task automatic compare_step();
        seg_game_pkg::seg_vec_t want_seg;
        int                     errs;
        want_seg = expected_seg_n(cyc);
        errs     = 0;
        if (pos != exp_pos) begin
            $display("MISMATCH at %0t: step %0d pos %0d, expected %0d",
                     $time, check_step, pos, exp_pos);
            errs++;
        end
        if (state_out != exp_state) begin
            $display("MISMATCH at %0t: step %0d state %s, expected %s",
                     $time, check_step, state_out.name(), exp_state.name());
            errs++;
        end
        if (seg_n != want_seg) begin
            $display("MISMATCH at %0t: step %0d seg_n %b, expected %b",
                     $time, check_step, seg_n, want_seg);
            errs++;
        end
        test_count++;
        error_count += errs;
        if (errs == 0) begin
            $display("step %0d ok: pos %0d state %s seg_n %b",
                     check_step, pos, state_out.name(), seg_n);
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            cyc         = 0;
            entry_cyc   = 1;
            prev_state  = seg_game_pkg::INITIAL;
            test_count  = 0;
            error_count = 0;
        end else begin
            cyc = cyc + 1;
            if (state_out != prev_state) begin
                check_transition();
            end
            if (check_req) begin
                compare_step();
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/seg_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module seg_game_tb;

    logic                      clk;
    logic                      rst;
    // Bits are right, left, up and down
    logic [3:0]                buttons;
    seg_game_pkg::seg_vec_t    seg_n;
    seg_game_pkg::seg_idx_t    pos;
    seg_game_pkg::game_state_t state_out;

    // Expected values handed to the checker
    logic                      check_req;
    int                        check_step;
    seg_game_pkg::seg_idx_t    exp_pos;
    seg_game_pkg::seg_vec_t    exp_record;
    seg_game_pkg::game_state_t exp_state;
    int                        test_count;
    int                        error_count;

    // Step table
    // Button code 0 means none and 1 to 4 pick a bit of buttons
    int                        step_button[$];
    int                        step_hold[$];
    seg_game_pkg::game_state_t step_wait[$];
    seg_game_pkg::seg_idx_t    step_pos[$];
    seg_game_pkg::seg_vec_t    step_record[$];
    seg_game_pkg::game_state_t step_state[$];

    integer                    seed;
    logic                      timed_out;

    seg_game_top dut (
        .clk       (clk),
        .rst       (rst),
        .right     (buttons[0]),
        .left      (buttons[1]),
        .up        (buttons[2]),
        .down      (buttons[3]),
        .seg_n     (seg_n),
        .pos       (pos),
        .state_out (state_out)
    );

    seg_game_checker result_checker (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic void add_step(input int button, input int hold,
                                     input seg_game_pkg::game_state_t wait_state,
                                     input seg_game_pkg::seg_idx_t pos_val,
                                     input seg_game_pkg::seg_vec_t record_val,
                                     input seg_game_pkg::game_state_t state_val);
        step_button.push_back(button);
        step_hold.push_back(hold);
        step_wait.push_back(wait_state);
        step_pos.push_back(pos_val);
        step_record.push_back(record_val);
        step_state.push_back(state_val);
    endfunction

    function automatic void build_table();
        // Presses while waiting in INITIAL are ignored
        add_step(0, 0,  seg_game_pkg::INITIAL, 3'd0, 7'h00, seg_game_pkg::INITIAL);
        add_step(1, 40, seg_game_pkg::INITIAL, 3'd0, 7'h00, seg_game_pkg::INITIAL);
        add_step(3, 40, seg_game_pkg::INITIAL, 3'd0, 7'h00, seg_game_pkg::INITIAL);
        // Ring moves with wrap and then moves to and from g
        add_step(1, 40, seg_game_pkg::MOVING,  3'd1, 7'h00, seg_game_pkg::MOVING);
        add_step(2, 40, seg_game_pkg::MOVING,  3'd0, 7'h00, seg_game_pkg::MOVING);
        add_step(2, 40, seg_game_pkg::MOVING,  3'd5, 7'h00, seg_game_pkg::MOVING);
        add_step(1, 40, seg_game_pkg::MOVING,  3'd0, 7'h00, seg_game_pkg::MOVING);
        add_step(3, 40, seg_game_pkg::MOVING,  3'd6, 7'h00, seg_game_pkg::MOVING);
        add_step(1, 40, seg_game_pkg::MOVING,  3'd1, 7'h00, seg_game_pkg::MOVING);
        add_step(3, 40, seg_game_pkg::MOVING,  3'd6, 7'h00, seg_game_pkg::MOVING);
        add_step(2, 40, seg_game_pkg::MOVING,  3'd5, 7'h00, seg_game_pkg::MOVING);
        add_step(3, 40, seg_game_pkg::MOVING,  3'd6, 7'h00, seg_game_pkg::MOVING);
        add_step(3, 40, seg_game_pkg::MOVING,  3'd0, 7'h00, seg_game_pkg::MOVING);
        // Only two samples high so no move
        add_step(1, 8,  seg_game_pkg::MOVING,  3'd0, 7'h00, seg_game_pkg::MOVING);
        // Stamp all seven segments and the last one empties the record
        add_step(4, 40, seg_game_pkg::MOVING,  3'd0, 7'h01, seg_game_pkg::INITIAL);
        add_step(1, 40, seg_game_pkg::MOVING,  3'd1, 7'h01, seg_game_pkg::MOVING);
        add_step(4, 40, seg_game_pkg::MOVING,  3'd1, 7'h03, seg_game_pkg::INITIAL);
        add_step(1, 40, seg_game_pkg::MOVING,  3'd2, 7'h03, seg_game_pkg::MOVING);
        add_step(4, 40, seg_game_pkg::MOVING,  3'd2, 7'h07, seg_game_pkg::INITIAL);
        add_step(1, 40, seg_game_pkg::MOVING,  3'd3, 7'h07, seg_game_pkg::MOVING);
        add_step(4, 40, seg_game_pkg::MOVING,  3'd3, 7'h0f, seg_game_pkg::INITIAL);
        add_step(1, 40, seg_game_pkg::MOVING,  3'd4, 7'h0f, seg_game_pkg::MOVING);
        add_step(4, 40, seg_game_pkg::MOVING,  3'd4, 7'h1f, seg_game_pkg::INITIAL);
        add_step(1, 40, seg_game_pkg::MOVING,  3'd5, 7'h1f, seg_game_pkg::MOVING);
        add_step(4, 40, seg_game_pkg::MOVING,  3'd5, 7'h3f, seg_game_pkg::INITIAL);
        add_step(3, 40, seg_game_pkg::MOVING,  3'd6, 7'h3f, seg_game_pkg::MOVING);
        add_step(4, 40, seg_game_pkg::MOVING,  3'd6, 7'h00, seg_game_pkg::INITIAL);
    endfunction

    task automatic apply_press(input int button, input int hold);
        @(posedge clk);
        buttons[button-1] <= 1'b1;
        repeat (hold) @(posedge clk);
        buttons[button-1] <= 1'b0;
        repeat (40) @(posedge clk);
    endtask

    task automatic wait_for_state(input seg_game_pkg::game_state_t want, input int step);
        int waited;
        waited = 0;
        @(negedge clk);
        while (state_out != want && waited < 2000) begin
            @(negedge clk);
            waited++;
        end
        if (state_out != want) begin
            $display("Timeout at step %0d: state_out did not reach %s within 2000 cycles",
                     step, want.name());
            timed_out = 1'b1;
        end
    endtask

    // A stamp is only finished once FALLING is over
    task automatic wait_out_falling(input int step);
        int waited;
        waited = 0;
        @(negedge clk);
        while (state_out == seg_game_pkg::FALLING && waited < 2000) begin
            @(negedge clk);
            waited++;
        end
        if (state_out == seg_game_pkg::FALLING) begin
            $display("Timeout at step %0d: state_out stayed in FALLING for 2000 cycles",
                     step);
            timed_out = 1'b1;
        end
    endtask

    task automatic hand_over(input int step);
        @(posedge clk);
        check_step <= step;
        exp_pos    <= step_pos[step];
        exp_record <= step_record[step];
        exp_state  <= step_state[step];
        check_req  <= 1'b1;
        @(posedge clk);
        check_req  <= 1'b0;
    endtask

    initial begin
        int gap;
        rst        = 1'b1;
        buttons    = '0;
        check_req  = 1'b0;
        check_step = 0;
        exp_pos    = '0;
        exp_record = '0;
        exp_state  = seg_game_pkg::INITIAL;
        seed       = 32'h5a94;
        timed_out  = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < step_button.size() && !timed_out; i++) begin
            gap = 40 + int'($unsigned($random(seed)) % 31);
            repeat (gap) @(posedge clk);
            wait_for_state(step_wait[i], i);
            if (!timed_out && step_button[i] != 0) begin
                apply_press(step_button[i], step_hold[i]);
            end
            if (!timed_out) begin
                wait_out_falling(i);
            end
            if (!timed_out) begin
                hand_over(i);
            end
        end
        repeat (2) @(posedge clk);
        $display("Tests: %0d, errors: %0d", test_count, error_count);
        if (timed_out || error_count != 0 || test_count == 0) begin
            $display("** FAIL **");
        end else begin
            $display("** PASS **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: seg_game.f
hdl/seg_game_pkg.sv
hdl/tick_gen.sv
hdl/button_conditioner.sv
hdl/cursor_fsm.sv
hdl/segment_flasher.sv
hdl/seg_game_top.sv
dv/seg_game_checker.sv
dv/seg_game_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the seg_game testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f seg_game.f --top-module seg_game_tb -Mdir "$BUILD" -o seg_game_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD/seg_game_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -F "** FAIL **" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
